/* verilog/btb_pkg.sv */
package btb_pkg;

    // pc = tag | index | byte offset
    localparam int PC_W     = 32;
    localparam int OFFSET_W = 2;
    localparam int INDEX_W  = 3;
    localparam int TAG_W    = PC_W - INDEX_W - OFFSET_W;
    localparam int NUM_SETS = 1 << INDEX_W;

    localparam int CTR_W = 2;

    // One way holds valid, tag, target and counter from msb down
    localparam int CTR_LSB    = 0;
    localparam int TARGET_LSB = CTR_LSB + CTR_W;
    localparam int TAG_LSB    = TARGET_LSB + PC_W;
    localparam int VALID_POS  = TAG_LSB + TAG_W;
    localparam int ENTRY_W    = VALID_POS + 1;

    typedef logic [PC_W-1:0]      pc_t;
    typedef logic [TAG_W-1:0]     tag_t;
    typedef logic [INDEX_W-1:0]   index_t;
    typedef logic [CTR_W-1:0]     ctr_t;
    typedef logic [ENTRY_W-1:0]   entry_t;
    typedef logic [2*ENTRY_W-1:0] set_t;    // way 1 in the upper half

    // Upper counter bit means taken
    localparam ctr_t CTR_WEAK_TAKEN = 2'd2;
    localparam ctr_t CTR_MAX        = 2'd3;

endpackage

/* verilog/btb_file.sv */
`timescale 1ns/1ns

module btb_file (
    input  logic            clk,
    input  logic            rst,
    input  btb_pkg::index_t read_index,
    input  btb_pkg::index_t update_index,
    input  logic            write_en,
    input  btb_pkg::set_t   write_set,
    output btb_pkg::set_t   read_set,
    output btb_pkg::set_t   update_set
);

    btb_pkg::set_t sets [btb_pkg::NUM_SETS];

    // Valid bit of each way in each set
    logic [btb_pkg::NUM_SETS-1:0][1:0] valid_bits;

    // Whole set written back at the stage index
    always_ff @(posedge clk) begin
        if (write_en) begin
            sets[update_index] <= write_set;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_bits <= '0;
        end else if (write_en) begin
            valid_bits[update_index][0] <= write_set[btb_pkg::VALID_POS];
            valid_bits[update_index][1] <= write_set[btb_pkg::ENTRY_W + btb_pkg::VALID_POS];
        end
    end

    // Lookup port
    always_comb begin
        read_set = sets[read_index];
        read_set[btb_pkg::VALID_POS] = valid_bits[read_index][0];
        read_set[btb_pkg::ENTRY_W + btb_pkg::VALID_POS] = valid_bits[read_index][1];
    end

    // Update port sees the write of the previous edge
    always_comb begin
        update_set = sets[update_index];
        update_set[btb_pkg::VALID_POS] = valid_bits[update_index][0];
        update_set[btb_pkg::ENTRY_W + btb_pkg::VALID_POS] = valid_bits[update_index][1];
    end

endmodule

/* verilog/btb_read.sv */
`timescale 1ns/1ns

module btb_read (
    input  btb_pkg::set_t read_set,
    input  btb_pkg::tag_t read_tag,
    output logic          hit,
    output logic          hit_way,
    output logic          taken,
    output btb_pkg::pc_t  target
);

    btb_pkg::entry_t way0;
    btb_pkg::entry_t way1;
    btb_pkg::entry_t sel;
    btb_pkg::tag_t   tag0;
    btb_pkg::tag_t   tag1;
    btb_pkg::ctr_t   sel_ctr;
    logic            match0;
    logic            match1;

    assign way0 = read_set[btb_pkg::ENTRY_W-1:0];
    assign way1 = read_set[2*btb_pkg::ENTRY_W-1:btb_pkg::ENTRY_W];

    assign tag0 = way0[btb_pkg::TAG_LSB +: btb_pkg::TAG_W];
    assign tag1 = way1[btb_pkg::TAG_LSB +: btb_pkg::TAG_W];

    assign match0 = way0[btb_pkg::VALID_POS] && (tag0 == read_tag);
    assign match1 = way1[btb_pkg::VALID_POS] && (tag1 == read_tag);

    assign hit     = match0 || match1;
    assign hit_way = !match0 && match1;   // Way 0 has priority
    assign sel     = hit_way ? way1 : way0;
    assign sel_ctr = sel[btb_pkg::CTR_LSB +: btb_pkg::CTR_W];

    always_comb begin
        if (hit) begin
            target = sel[btb_pkg::TARGET_LSB +: btb_pkg::PC_W];
            taken  = sel_ctr[btb_pkg::CTR_W-1];
        end else begin
            target = '0;
            taken  = 1'b0;
        end
    end

endmodule

/* verilog/btb_write.sv */
`timescale 1ns/1ns

module btb_write (
    input  logic          pending,
    input  btb_pkg::set_t update_set,
    input  btb_pkg::tag_t update_tag,
    input  btb_pkg::pc_t  update_target,
    input  logic          update_taken,
    input  logic          lru_way,
    output btb_pkg::set_t write_set,
    output logic          write_en,
    output logic          write_way
);

    btb_pkg::entry_t way0;
    btb_pkg::entry_t way1;
    btb_pkg::entry_t old_entry;
    btb_pkg::entry_t new_entry;
    btb_pkg::ctr_t   old_ctr;
    btb_pkg::ctr_t   new_ctr;
    logic            match0;
    logic            match1;
    logic            hit;
    logic            hit_way;

    assign way0 = update_set[btb_pkg::ENTRY_W-1:0];
    assign way1 = update_set[2*btb_pkg::ENTRY_W-1:btb_pkg::ENTRY_W];

    assign match0 = way0[btb_pkg::VALID_POS]
                    && (way0[btb_pkg::TAG_LSB +: btb_pkg::TAG_W] == update_tag);
    assign match1 = way1[btb_pkg::VALID_POS]
                    && (way1[btb_pkg::TAG_LSB +: btb_pkg::TAG_W] == update_tag);

    assign hit     = match0 || match1;
    assign hit_way = !match0 && match1;

    assign old_entry = hit_way ? way1 : way0;
    assign old_ctr   = old_entry[btb_pkg::CTR_LSB +: btb_pkg::CTR_W];

    // Saturating counter
    always_comb begin
        if (update_taken) begin
            new_ctr = (old_ctr == btb_pkg::CTR_MAX) ? old_ctr : old_ctr + 1'b1;
        end else begin
            new_ctr = (old_ctr == '0) ? old_ctr : old_ctr - 1'b1;
        end
    end

    always_comb begin
        if (hit) begin
            // Train in place
            new_entry = old_entry;
            new_entry[btb_pkg::TARGET_LSB +: btb_pkg::PC_W] = update_target;
            new_entry[btb_pkg::CTR_LSB +: btb_pkg::CTR_W]   = new_ctr;
        end else begin
            new_entry = '0;
            new_entry[btb_pkg::VALID_POS]                   = 1'b1;
            new_entry[btb_pkg::TAG_LSB +: btb_pkg::TAG_W]   = update_tag;
            new_entry[btb_pkg::TARGET_LSB +: btb_pkg::PC_W] = update_target;
            new_entry[btb_pkg::CTR_LSB +: btb_pkg::CTR_W]   = btb_pkg::CTR_WEAK_TAKEN;
        end
    end

    assign write_way = hit ? hit_way : lru_way;   // Allocate into LRU way on miss

    // Other way passes through untouched
    always_comb begin
        write_set = update_set;
        if (write_way) begin
            write_set[btb_pkg::ENTRY_W +: btb_pkg::ENTRY_W] = new_entry;
        end else begin
            write_set[0 +: btb_pkg::ENTRY_W] = new_entry;
        end
    end

    // Not-taken miss leaves the set alone
    assign write_en = pending && (hit || update_taken);

endmodule

/* verilog/btb_lru.sv */
`timescale 1ns/1ns

module btb_lru (
    input  logic            clk,
    input  logic            rst,
    input  btb_pkg::index_t read_index,
    input  logic            read_hit,
    input  logic            read_way,
    input  btb_pkg::index_t write_index,
    input  logic            write_en,
    input  logic            write_way,
    output logic            update_lru_way
);

    // One bit per set naming the way to replace
    logic [btb_pkg::NUM_SETS-1:0] lru;
    logic [btb_pkg::NUM_SETS-1:0] lru_next;

    always_comb begin
        lru_next = lru;
        if (read_hit) begin
            lru_next[read_index] = ~read_way;
        end
        // Write applied last so it wins on the same set
        if (write_en) begin
            lru_next[write_index] = ~write_way;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lru <= '0;
        end else begin
            lru <= lru_next;
        end
    end

    assign update_lru_way = lru[write_index];

endmodule

/* verilog/btb.sv */
`timescale 1ns/1ns

module btb (
    input  logic         clk,
    input  logic         rst,
    input  btb_pkg::pc_t pc,
    input  logic         update,
    input  btb_pkg::pc_t update_pc,
    input  btb_pkg::pc_t update_target,
    input  logic         update_taken,
    output btb_pkg::pc_t target_pc,
    output logic         valid,
    output logic         predicted_taken
);

    btb_pkg::index_t read_index;
    btb_pkg::tag_t   read_tag;
    btb_pkg::set_t   read_set;
    logic            read_hit;
    logic            read_way;

    // Update stage holding one branch
    logic            upd_pending;
    btb_pkg::pc_t    upd_pc;
    btb_pkg::pc_t    upd_target;
    logic            upd_taken;

    btb_pkg::index_t upd_index;
    btb_pkg::tag_t   upd_tag;
    btb_pkg::set_t   update_set;
    btb_pkg::set_t   write_set;
    logic            write_en;
    logic            write_way;
    logic            lru_way;

    assign read_index = pc[btb_pkg::OFFSET_W +: btb_pkg::INDEX_W];
    assign read_tag   = pc[btb_pkg::OFFSET_W + btb_pkg::INDEX_W +: btb_pkg::TAG_W];

    assign upd_index = upd_pc[btb_pkg::OFFSET_W +: btb_pkg::INDEX_W];
    assign upd_tag   = upd_pc[btb_pkg::OFFSET_W + btb_pkg::INDEX_W +: btb_pkg::TAG_W];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            upd_pending <= 1'b0;
        end else begin
            upd_pending <= update;
        end
    end

    always_ff @(posedge clk) begin
        if (update) begin
            upd_pc     <= update_pc;
            upd_target <= update_target;
            upd_taken  <= update_taken;
        end
    end

    btb_file u_file (
        .clk          (clk),
        .rst          (rst),
        .read_index   (read_index),
        .update_index (upd_index),
        .write_en     (write_en),
        .write_set    (write_set),
        .read_set     (read_set),
        .update_set   (update_set)
    );

    btb_read u_read (
        .read_set (read_set),
        .read_tag (read_tag),
        .hit      (read_hit),
        .hit_way  (read_way),
        .taken    (predicted_taken),
        .target   (target_pc)
    );

    assign valid = read_hit;

    btb_write u_write (
        .pending       (upd_pending),
        .update_set    (update_set),
        .update_tag    (upd_tag),
        .update_target (upd_target),
        .update_taken  (upd_taken),
        .lru_way       (lru_way),
        .write_set     (write_set),
        .write_en      (write_en),
        .write_way     (write_way)
    );

    btb_lru u_lru (
        .clk            (clk),
        .rst            (rst),
        .read_index     (read_index),
        .read_hit       (read_hit),
        .read_way       (read_way),
        .write_index    (upd_index),
        .write_en       (write_en),
        .write_way      (write_way),
        .update_lru_way (lru_way)
    );

endmodule

/* tb/btb_tb.sv */
`timescale 1ns/1ns

module btb_tb;

    localparam int          RESET_TIMEOUT = 20;
    localparam int          CHECK_DELAY   = 4;     // Just before the rising edge
    localparam int          NUM_FILLERS   = 4;
    localparam logic [15:0] LFSR_SEED     = 16'd12630;

    // Set 6 is never updated so a parked pc never hits
    localparam btb_pkg::pc_t PARK_PC = 32'h0000_0018;

    typedef enum logic [1:0] {
        OP_LOOKUP,
        OP_UPDATE,        // Pulse then one idle cycle
        OP_UPDATE_B2B     // Pulse with the next row right after
    } op_t;

    typedef struct packed {
        op_t          op;
        btb_pkg::pc_t pc;
        btb_pkg::pc_t target;
        logic         taken;
        logic         exp_valid;
        logic         exp_taken;
        btb_pkg::pc_t exp_target;
    } row_t;

    logic         clk;
    logic         rst;
    btb_pkg::pc_t pc;
    logic         update;
    btb_pkg::pc_t update_pc;
    btb_pkg::pc_t update_target;
    logic         update_taken;
    btb_pkg::pc_t target_pc;
    logic         valid;
    logic         predicted_taken;

    row_t        rows[$];
    logic [15:0] lfsr;
    int          valid_errors;
    int          taken_errors;
    int          target_errors;
    int          timeout_errors;

    btb u_btb (
        .clk             (clk),
        .rst             (rst),
        .pc              (pc),
        .update          (update),
        .update_pc       (update_pc),
        .update_target   (update_target),
        .update_taken    (update_taken),
        .target_pc       (target_pc),
        .valid           (valid),
        .predicted_taken (predicted_taken)
    );

    initial begin
        clk = 1'b0;
    end

    always #5 clk = ~clk;

    initial begin
        rst = 1'b1;
        repeat (5) @(negedge clk);
        rst = 1'b0;
    end

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] next_lfsr(input logic [15:0] state);
        logic fb;
        fb = state[15] ^ state[13] ^ state[12] ^ state[10];
        next_lfsr = {state[14:0], fb};
    endfunction

    function automatic btb_pkg::pc_t make_pc(input btb_pkg::tag_t tag,
                                             input btb_pkg::index_t index);
        make_pc = {tag, index, 2'b00};
    endfunction

    task automatic add_lookup(input btb_pkg::pc_t addr, input logic exp_valid,
                              input logic exp_taken, input btb_pkg::pc_t exp_target);
        row_t r;
        r = '0;
        r.op         = OP_LOOKUP;
        r.pc         = addr;
        r.exp_valid  = exp_valid;
        r.exp_taken  = exp_taken;
        r.exp_target = exp_target;
        rows.push_back(r);
    endtask

    task automatic add_update(input op_t op, input btb_pkg::pc_t addr,
                              input btb_pkg::pc_t dest, input logic taken_bit);
        row_t r;
        r = '0;
        r.op     = op;
        r.pc     = addr;
        r.target = dest;
        r.taken  = taken_bit;
        rows.push_back(r);
    endtask

    task automatic build_table();
        btb_pkg::tag_t tag;
        btb_pkg::pc_t  alloc_pc;
        btb_pkg::pc_t  nt_pc;
        btb_pkg::pc_t  train_pc;
        btb_pkg::pc_t  a_pc;
        btb_pkg::pc_t  b_pc;
        btb_pkg::pc_t  c_pc;
        btb_pkg::pc_t  a4_pc;
        btb_pkg::pc_t  b4_pc;
        alloc_pc = make_pc(27'h11, 3'd0);
        nt_pc    = make_pc(27'h22, 3'd1);
        train_pc = make_pc(27'h33, 3'd2);
        a_pc     = make_pc(27'h41, 3'd3);
        b_pc     = make_pc(27'h42, 3'd3);
        c_pc     = make_pc(27'h43, 3'd3);
        a4_pc    = make_pc(27'h51, 3'd4);
        b4_pc    = make_pc(27'h52, 3'd4);

        // Random fillers live in set 7 and must miss
        for (int n = 0; n < NUM_FILLERS; n++) begin
            for (int b = 0; b < btb_pkg::TAG_W; b++) begin
                lfsr   = next_lfsr(lfsr);
                tag[b] = lfsr[0];
            end
            add_lookup(make_pc(tag, 3'd7), 1'b0, 1'b0, '0);
        end
        add_lookup(alloc_pc, 1'b0, 1'b0, '0);

        add_update(OP_UPDATE, alloc_pc, 32'h0000_1000, 1'b1);
        add_lookup(alloc_pc, 1'b1, 1'b1, 32'h0000_1000);
        add_update(OP_UPDATE, nt_pc, 32'h0000_1100, 1'b0);    // Not-taken miss writes nothing
        add_lookup(nt_pc, 1'b0, 1'b0, '0);

        add_update(OP_UPDATE, train_pc, 32'h0000_2000, 1'b1); // Counter 2
        add_lookup(train_pc, 1'b1, 1'b1, 32'h0000_2000);
        add_update(OP_UPDATE, train_pc, 32'h0000_2000, 1'b0);
        add_update(OP_UPDATE, train_pc, 32'h0000_2000, 1'b0); // Counter 0
        add_lookup(train_pc, 1'b1, 1'b0, 32'h0000_2000);
        add_update(OP_UPDATE, train_pc, 32'h0000_2000, 1'b1);
        add_update(OP_UPDATE, train_pc, 32'h0000_2000, 1'b1); // Back to 2
        add_lookup(train_pc, 1'b1, 1'b1, 32'h0000_2000);
        // Saturates at 3 so one not-taken leaves it at 2
        repeat (3) add_update(OP_UPDATE, train_pc, 32'h0000_2000, 1'b1);
        add_update(OP_UPDATE, train_pc, 32'h0000_2000, 1'b0);
        add_lookup(train_pc, 1'b1, 1'b1, 32'h0000_2000);

        add_update(OP_UPDATE, train_pc, 32'h0000_2400, 1'b1); // New target
        add_lookup(train_pc, 1'b1, 1'b1, 32'h0000_2400);

        add_update(OP_UPDATE, a_pc, 32'h0000_3100, 1'b1);     // Way 0
        add_update(OP_UPDATE, b_pc, 32'h0000_3200, 1'b1);     // Way 1
        add_lookup(a_pc, 1'b1, 1'b1, 32'h0000_3100);          // Way 1 now LRU
        add_update(OP_UPDATE, c_pc, 32'h0000_3300, 1'b1);
        add_lookup(a_pc, 1'b1, 1'b1, 32'h0000_3100);
        add_lookup(c_pc, 1'b1, 1'b1, 32'h0000_3300);
        add_lookup(b_pc, 1'b0, 1'b0, '0);

        add_update(OP_UPDATE_B2B, a4_pc, 32'h0000_4100, 1'b1);
        add_update(OP_UPDATE, b4_pc, 32'h0000_4200, 1'b1);
        add_lookup(a4_pc, 1'b1, 1'b1, 32'h0000_4100);
        add_lookup(b4_pc, 1'b1, 1'b1, 32'h0000_4200);
    endtask

    task automatic wait_for_reset(output logic released);
        int cycles;
        cycles = 0;
        while (rst !== 1'b0 && cycles < RESET_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        released = (rst === 1'b0);
    endtask

    // Starts and ends on a falling edge
    task automatic drive_update(input row_t r);
        pc            = PARK_PC;
        update        = 1'b1;
        update_pc     = r.pc;
        update_target = r.target;
        update_taken  = r.taken;
        @(negedge clk);
        update = 1'b0;
        if (r.op == OP_UPDATE) begin
            @(negedge clk);
        end
    endtask

    task automatic check_lookup(input row_t r, input int idx);
        pc = r.pc;
        #CHECK_DELAY;
        assert (valid === r.exp_valid) else begin
            valid_errors++;
            $display("Fail %0t ns: row %0d pc %h valid %b, expected %b",
                     $time, idx, r.pc, valid, r.exp_valid);
        end
        assert (predicted_taken === r.exp_taken) else begin
            taken_errors++;
            $display("Fail %0t ns: row %0d pc %h predicted_taken %b, expected %b",
                     $time, idx, r.pc, predicted_taken, r.exp_taken);
        end
        assert (target_pc === r.exp_target) else begin
            target_errors++;
            $display("Fail %0t ns: row %0d pc %h target_pc %h, expected %h",
                     $time, idx, r.pc, target_pc, r.exp_target);
        end
        @(negedge clk);
    endtask

    task automatic report_counts();
        $display("Errors: valid %0d, taken %0d, target %0d, timeout %0d",
                 valid_errors, taken_errors, target_errors, timeout_errors);
    endtask

    initial begin
        logic released;
        pc             = PARK_PC;
        update         = 1'b0;
        update_pc      = '0;
        update_target  = '0;
        update_taken   = 1'b0;
        valid_errors   = 0;
        taken_errors   = 0;
        target_errors  = 0;
        timeout_errors = 0;
        lfsr           = LFSR_SEED;
        build_table();

        wait_for_reset(released);
        if (!released) begin
            timeout_errors++;
            $display("Reset still asserted after %0d cycles", RESET_TIMEOUT);
            report_counts();
            $display("tests failed");
            $finish;
        end else begin
            foreach (rows[i]) begin
                if (rows[i].op == OP_LOOKUP) begin
                    check_lookup(rows[i], i);
                end else begin
                    drive_update(rows[i]);
                end
            end
            report_counts();
            if (valid_errors + taken_errors + target_errors + timeout_errors == 0) begin
                $display("all tests passed");
            end else begin
                $display("tests failed");
            end
            $finish;
        end
    end

endmodule

/* vlog.f */
verilog/btb_pkg.sv
verilog/btb_file.sv
verilog/btb_read.sv
verilog/btb_write.sv
verilog/btb_lru.sv
verilog/btb.sv
tb/btb_tb.sv
